//--- mm_top.f
hdl/mm_pkg.sv
hdl/mm_buffer.sv
hdl/wb_host_port.sv
hdl/mm_sequencer.sv
hdl/mac_unit.sv
hdl/mm_top.sv
bench/mm_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mm_top_tb
FILELIST ?= mm_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mm_top_tb.sv
module mm_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_dim = 8;
  localparam int runs = 6; // engine runs over all tests
  localparam int cycle_limit = runs * 800 + 200;

  localparam int kind_ack = 0;
  localparam int kind_reg = 1;
  localparam int kind_flag = 2;
  localparam int kind_result = 3;

  logic                          arm_clk;
  logic                          rst;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [mm_pkg::adr_width-1:0]  wb_adr;
  logic [mm_pkg::data_width-1:0] wb_dat_i;
  logic [mm_pkg::data_width-1:0] wb_dat_o;
  logic                          wb_ack;

  logic [31:0] rng_state = 32'd63966;
  logic [7:0]  feat [max_dim][max_dim]; // [i][k]
  logic [7:0]  wt [max_dim][max_dim];   // [k][j]
  int          ref_out [max_dim][max_dim];
  int          dim_m;
  int          dim_n;
  int          dim_p;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycles = 0;

  // values the tasks latch for the assertions below
  logic        chk_ack = 1'b0;
  logic        chk_reg = 1'b0;
  logic        chk_flag = 1'b0;
  logic        chk_result = 1'b0;
  logic [31:0] chk_got = '0;
  logic [31:0] chk_exp = '0;
  string       chk_msg = "";

  mm_top #(.max_dim(max_dim)) mm_top_i (
    .arm_clk  (arm_clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  initial begin
    arm_clk = 1'b0;
    forever #10 arm_clk = ~arm_clk;
  end

  always @(posedge arm_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the cycle limit of %0d was reached before the tests ended",
               cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic report_mismatch();
    errors++;
    $display("Error at %0t: %s, got %0h expected %0h", $time, chk_msg, chk_got, chk_exp);
  endtask

  ack_one_cycle: assert property (@(posedge arm_clk) chk_ack |-> chk_got == chk_exp)
    else report_mismatch();
  reg_readback: assert property (@(posedge arm_clk) chk_reg |-> chk_got == chk_exp)
    else report_mismatch();
  flag_value: assert property (@(posedge arm_clk) chk_flag |-> chk_got == chk_exp)
    else report_mismatch();
  result_match: assert property (@(posedge arm_clk) chk_result |-> chk_got == chk_exp)
    else report_mismatch();

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // all bus tasks start and end on a falling edge
  task automatic bus_write(input logic [1:0] region, input int off, input logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = {region, 8'(off)};
    wb_dat_i = data;
    @(negedge arm_clk);
    while (!wb_ack) @(negedge arm_clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] region, input int off,
                          output logic [31:0] data, output int waited);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = {region, 8'(off)};
    waited = 0;
    do begin
      @(negedge arm_clk);
      waited++;
    end while (!wb_ack);
    data = wb_dat_o; // valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic expect_value(input int kind, input logic [31:0] got,
                              input logic [31:0] exp, input string msg);
    chk_got = got;
    chk_exp = exp;
    chk_msg = msg;
    chk_ack = (kind == kind_ack);
    chk_reg = (kind == kind_reg);
    chk_flag = (kind == kind_flag);
    chk_result = (kind == kind_result);
    checks++;
    @(negedge arm_clk); // one rising edge for the assertion
    chk_ack = 1'b0;
    chk_reg = 1'b0;
    chk_flag = 1'b0;
    chk_result = 1'b0;
  endtask

  task automatic random_dims();
    dim_m = int'(next_rand() % 32'd8) + 1;
    dim_n = int'(next_rand() % 32'd8) + 1;
    dim_p = int'(next_rand() % 32'd8) + 1;
  endtask

  // every entry random, so padding lanes get random bytes too
  task automatic fill_features();
    for (int i = 0; i < max_dim; i++)
      for (int k = 0; k < max_dim; k++)
        feat[i][k] = 8'(next_rand());
  endtask

  task automatic fill_weights();
    for (int k = 0; k < max_dim; k++)
      for (int j = 0; j < max_dim; j++)
        wt[k][j] = 8'(next_rand());
  endtask

  task automatic load_features();
    int          wpc;
    logic [31:0] word;
    wpc = (dim_m + 3) / 4;
    for (int k = 0; k < dim_n; k++) begin
      for (int w = 0; w < wpc; w++) begin
        for (int lane = 0; lane < 4; lane++)
          word[8*lane +: 8] = feat[w*4 + lane][k];
        bus_write(mm_pkg::region_feat, k * wpc + w, word);
      end
    end
  endtask

  task automatic load_weights();
    int          wpc;
    logic [31:0] word;
    wpc = (dim_p + 3) / 4;
    for (int k = 0; k < dim_n; k++) begin
      for (int w = 0; w < wpc; w++) begin
        for (int lane = 0; lane < 4; lane++)
          word[8*lane +: 8] = wt[k][w*4 + lane];
        bus_write(mm_pkg::region_weight, k * wpc + w, word);
      end
    end
  endtask

  task automatic write_dims();
    bus_write(mm_pkg::region_ctrl, int'(mm_pkg::reg_com1), {16'(dim_p), 16'(dim_m)});
    bus_write(mm_pkg::region_ctrl, int'(mm_pkg::reg_com2), {16'd0, 16'(dim_n)});
  endtask

  // unsigned feature times signed weight
  task automatic compute_reference();
    int sum;
    int fv;
    int wv;
    for (int i = 0; i < dim_m; i++) begin
      for (int j = 0; j < dim_p; j++) begin
        sum = 0;
        for (int k = 0; k < dim_n; k++) begin
          fv = int'(feat[i][k]);
          wv = int'(wt[k][j]);
          if (wv > 127) wv = wv - 256;
          sum = sum + fv * wv;
        end
        ref_out[i][j] = sum;
      end
    end
  endtask

  task automatic start_and_wait(input bit watch_flag);
    logic [31:0] flag;
    int          waited;
    bus_write(mm_pkg::region_ctrl, int'(mm_pkg::reg_flag), mm_pkg::flag_start);
    forever begin
      bus_read(mm_pkg::region_ctrl, int'(mm_pkg::reg_flag), flag, waited);
      if (flag == mm_pkg::flag_finish) break;
      if (watch_flag)
        expect_value(kind_flag, flag, mm_pkg::flag_start, "flag while running");
    end
  endtask

  task automatic check_results();
    logic [31:0] data;
    int          waited;
    for (int i = 0; i < dim_m; i++) begin
      for (int j = 0; j < dim_p; j++) begin
        bus_read(mm_pkg::region_out, i * dim_p + j, data, waited);
        expect_value(kind_result, data, 32'(ref_out[i][j]),
                     $sformatf("result (%0d,%0d) of %0dx%0dx%0d", i, j, dim_m, dim_n, dim_p));
      end
    end
  endtask

  task automatic full_run();
    fill_features();
    fill_weights();
    write_dims();
    load_features();
    load_weights();
    compute_reference();
    start_and_wait(1'b0);
    check_results();
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  initial begin
    int          e0;
    int          waited;
    logic [31:0] data;
    logic [31:0] v1;
    logic [31:0] v2;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_i = '0;
    repeat (5) @(negedge arm_clk);
    rst = 1'b0;

    e0 = errors;
    bus_read(mm_pkg::region_ctrl, int'(mm_pkg::reg_flag), data, waited);
    expect_value(kind_ack, 32'(waited), 32'd1, "cycles from request to ack");
    expect_value(kind_flag, data, mm_pkg::flag_idle, "flag after reset");
    end_test("reset state", e0);

    e0 = errors;
    v1 = next_rand();
    v2 = next_rand();
    bus_write(mm_pkg::region_ctrl, int'(mm_pkg::reg_com1), v1);
    bus_write(mm_pkg::region_ctrl, int'(mm_pkg::reg_com2), v2);
    bus_read(mm_pkg::region_ctrl, int'(mm_pkg::reg_com1), data, waited);
    expect_value(kind_reg, data, v1, "com1 readback");
    bus_read(mm_pkg::region_ctrl, int'(mm_pkg::reg_com2), data, waited);
    expect_value(kind_reg, data, v2, "com2 readback");
    end_test("command registers", e0);

    e0 = errors;
    random_dims();
    full_run();
    end_test("random dimensions", e0);

    e0 = errors;
    dim_m = 1;
    dim_n = 1;
    dim_p = 1;
    full_run();
    dim_m = max_dim;
    dim_n = max_dim;
    dim_p = max_dim;
    full_run();
    end_test("edge dimensions", e0);

    e0 = errors;
    random_dims();
    full_run();
    fill_features(); // weights stay from the first run
    load_features();
    compute_reference();
    start_and_wait(1'b0);
    check_results();
    end_test("back to back runs", e0);

    e0 = errors;
    random_dims();
    fill_features();
    fill_weights();
    write_dims();
    load_features();
    load_weights();
    compute_reference();
    start_and_wait(1'b1);
    for (int w = 0; w < dim_m * dim_p; w++)
      bus_write(mm_pkg::region_out, w, next_rand()); // must not land
    check_results();
    end_test("flag and output writes", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- hdl/mm_top.sv
module mm_top #(
  parameter int max_dim = 8
) (
  input  logic                          arm_clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [mm_pkg::adr_width-1:0]  wb_adr,
  input  logic [mm_pkg::data_width-1:0] wb_dat_i,
  output logic [mm_pkg::data_width-1:0] wb_dat_o,
  output logic                          wb_ack
);

  localparam int fw_depth = mm_pkg::fw_depth(max_dim);
  localparam int out_depth = mm_pkg::out_depth(max_dim);
  localparam int fw_aw = $clog2(fw_depth);
  localparam int out_aw = $clog2(out_depth);

  // host side
  logic                          start;
  logic                          done;
  mm_pkg::dim_t                  dim_m;
  mm_pkg::dim_t                  dim_n;
  mm_pkg::dim_t                  dim_p;
  logic                          feat_we;
  logic                          weight_we;
  logic [mm_pkg::off_width-1:0]  host_adr;
  mm_pkg::feat_word_t            host_wdata;
  mm_pkg::feat_word_t            feat_rdata;
  mm_pkg::feat_word_t            weight_rdata;
  mm_pkg::acc_t                  out_rdata;

  // engine side
  logic                          issue_valid;
  logic                          acc_first;
  logic                          acc_last;
  logic                          final_item;
  logic [fw_aw-1:0]              feat_adr;
  logic [fw_aw-1:0]              weight_adr;
  logic [out_aw-1:0]             out_adr;
  logic [1:0]                    feat_lane;
  logic [1:0]                    weight_lane;
  mm_pkg::feat_word_t            feat_word;
  mm_pkg::feat_word_t            weight_word;
  logic                          out_we;
  logic [out_aw-1:0]             out_wadr;
  mm_pkg::acc_t                  out_wdata;

  wb_host_port host_port (
    .arm_clk      (arm_clk),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .done         (done),
    .start        (start),
    .dim_m        (dim_m),
    .dim_n        (dim_n),
    .dim_p        (dim_p),
    .feat_we      (feat_we),
    .weight_we    (weight_we),
    .host_adr     (host_adr),
    .host_wdata   (host_wdata),
    .feat_rdata   (feat_rdata),
    .weight_rdata (weight_rdata),
    .out_rdata    (out_rdata)
  );

  // port a belongs to the host, port b to the engine
  mm_buffer #(.depth(fw_depth), .word_t(mm_pkg::feat_word_t)) feat_buf (
    .arm_clk (arm_clk),
    .a_we    (feat_we),
    .a_adr   (host_adr[fw_aw-1:0]),
    .a_wdata (host_wdata),
    .a_rdata (feat_rdata),
    .b_we    (1'b0),
    .b_adr   (feat_adr),
    .b_wdata ('0),
    .b_rdata (feat_word)
  );

  mm_buffer #(.depth(fw_depth), .word_t(mm_pkg::feat_word_t)) weight_buf (
    .arm_clk (arm_clk),
    .a_we    (weight_we),
    .a_adr   (host_adr[fw_aw-1:0]),
    .a_wdata (host_wdata),
    .a_rdata (weight_rdata),
    .b_we    (1'b0),
    .b_adr   (weight_adr),
    .b_wdata ('0),
    .b_rdata (weight_word)
  );

  mm_buffer #(.depth(out_depth), .word_t(mm_pkg::acc_t)) out_buf (
    .arm_clk (arm_clk),
    .a_we    (1'b0), // host only reads results
    .a_adr   (host_adr[out_aw-1:0]),
    .a_wdata ('0),
    .a_rdata (out_rdata),
    .b_we    (out_we),
    .b_adr   (out_wadr),
    .b_wdata (out_wdata),
    .b_rdata ()
  );

  mm_sequencer #(.max_dim(max_dim)) seq (
    .arm_clk     (arm_clk),
    .rst         (rst),
    .start       (start),
    .dim_m       (dim_m),
    .dim_n       (dim_n),
    .dim_p       (dim_p),
    .issue_valid (issue_valid),
    .acc_first   (acc_first),
    .acc_last    (acc_last),
    .final_item  (final_item),
    .feat_adr    (feat_adr),
    .weight_adr  (weight_adr),
    .out_adr     (out_adr),
    .feat_lane   (feat_lane),
    .weight_lane (weight_lane)
  );

  mac_unit #(.max_dim(max_dim)) mac (
    .arm_clk     (arm_clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .acc_first   (acc_first),
    .acc_last    (acc_last),
    .final_item  (final_item),
    .feat_lane   (feat_lane),
    .weight_lane (weight_lane),
    .out_adr     (out_adr),
    .feat_word   (feat_word),
    .weight_word (weight_word),
    .out_we      (out_we),
    .out_wadr    (out_wadr),
    .out_wdata   (out_wdata),
    .done        (done)
  );

endmodule

//--- hdl/mac_unit.sv
module mac_unit #(
  parameter int max_dim = 8,
  localparam int out_aw = $clog2(mm_pkg::out_depth(max_dim))
) (
  input  logic               arm_clk,
  input  logic               rst,
  input  logic               issue_valid,
  input  logic               acc_first,
  input  logic               acc_last,
  input  logic               final_item,
  input  logic [1:0]         feat_lane,
  input  logic [1:0]         weight_lane,
  input  logic [out_aw-1:0]  out_adr,
  input  mm_pkg::feat_word_t feat_word,
  input  mm_pkg::feat_word_t weight_word,
  output logic               out_we,
  output logic [out_aw-1:0]  out_wadr,
  output mm_pkg::acc_t       out_wdata,
  output logic               done
);

  logic                                v_d;
  logic                                first_d;
  logic                                last_d;
  logic                                final_d;
  logic [1:0]                          flane_d;
  logic [1:0]                          wlane_d;
  logic [out_aw-1:0]                   oadr_d;
  logic [mm_pkg::elem_width-1:0]       f_byte;
  logic [mm_pkg::elem_width-1:0]       w_byte;
  logic signed [2*mm_pkg::elem_width:0] prod;
  mm_pkg::acc_t                        acc;

  // tags wait one clock for the buffer read data
  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      v_d <= 1'b0;
      first_d <= 1'b0;
      last_d <= 1'b0;
      final_d <= 1'b0;
      out_we <= 1'b0;
      done <= 1'b0;
    end else begin
      v_d <= issue_valid;
      first_d <= acc_first;
      last_d <= acc_last;
      final_d <= final_item;
      out_we <= v_d && last_d;
      done <= v_d && last_d && final_d; // same clock as the final write
    end
  end

  assign f_byte = feat_word[flane_d];
  assign w_byte = weight_word[wlane_d];
  // feature unsigned, weight signed
  assign prod = $signed({1'b0, f_byte}) * $signed(w_byte);

  always_ff @(posedge arm_clk) begin
    flane_d <= feat_lane;
    wlane_d <= weight_lane;
    oadr_d <= out_adr;
    if (v_d) begin
      if (first_d) begin
        acc <= prod; // new dot product
      end else begin
        acc <= acc + prod;
      end
    end
    if (v_d && last_d) begin
      out_wadr <= oadr_d;
    end
  end

  assign out_wdata = acc;

  no_write_in_reset: assert property (@(posedge arm_clk) rst |-> !out_we)
    else $error("result write during reset");

endmodule

//--- hdl/mm_sequencer.sv
module mm_sequencer #(
  parameter int max_dim = 8,
  localparam int fw_aw = $clog2(mm_pkg::fw_depth(max_dim)),
  localparam int out_aw = $clog2(mm_pkg::out_depth(max_dim))
) (
  input  logic              arm_clk,
  input  logic              rst,
  input  logic              start,
  input  mm_pkg::dim_t      dim_m,
  input  mm_pkg::dim_t      dim_n,
  input  mm_pkg::dim_t      dim_p,
  output logic              issue_valid,
  output logic              acc_first,
  output logic              acc_last,
  output logic              final_item,
  output logic [fw_aw-1:0]  feat_adr,
  output logic [fw_aw-1:0]  weight_adr,
  output logic [out_aw-1:0] out_adr,
  output logic [1:0]        feat_lane,
  output logic [1:0]        weight_lane
);

  logic         busy;
  mm_pkg::dim_t m_r;
  mm_pkg::dim_t n_r;
  mm_pkg::dim_t p_r;
  mm_pkg::dim_t wpc_m; // packed words per feature column
  mm_pkg::dim_t wpc_p; // packed words per weight row
  mm_pkg::dim_t i;
  mm_pkg::dim_t j;
  mm_pkg::dim_t k;
  logic         i_end;
  logic         j_end;
  logic         k_end;
  mm_pkg::dim_t feat_sum;
  mm_pkg::dim_t weight_sum;
  mm_pkg::dim_t out_sum;

  assign i_end = (i == m_r - 16'd1);
  assign j_end = (j == p_r - 16'd1);
  assign k_end = (k == n_r - 16'd1);

  // dimensions frozen for the whole run
  always_ff @(posedge arm_clk) begin
    if (start && !busy) begin
      m_r <= dim_m;
      n_r <= dim_n;
      p_r <= dim_p;
      wpc_m <= (dim_m + 16'd3) >> 2;
      wpc_p <= (dim_p + 16'd3) >> 2;
    end
  end

  // i outer, j middle, k inner; one item per clock
  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      i <= '0;
      j <= '0;
      k <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
        i <= '0;
        j <= '0;
        k <= '0;
      end
    end else if (k_end) begin
      k <= '0;
      if (j_end) begin
        j <= '0;
        if (i_end) begin
          busy <= 1'b0; // last item issued
        end else begin
          i <= i + 16'd1;
        end
      end else begin
        j <= j + 16'd1;
      end
    end else begin
      k <= k + 16'd1;
    end
  end

  assign issue_valid = busy;
  assign acc_first = busy && (k == 16'd0);
  assign acc_last = busy && k_end;
  assign final_item = acc_last && j_end && i_end;

  // feature[i][k] and weight[k][j] word and lane
  assign feat_sum = k * wpc_m + (i >> 2);
  assign weight_sum = k * wpc_p + (j >> 2);
  assign out_sum = i * p_r + j; // row major results

  assign feat_adr = feat_sum[fw_aw-1:0];
  assign weight_adr = weight_sum[fw_aw-1:0];
  assign out_adr = out_sum[out_aw-1:0];
  assign feat_lane = i[1:0];
  assign weight_lane = j[1:0];

  dims_in_range: assert property (@(posedge arm_clk) disable iff (rst)
    start && !busy |->
      (dim_m >= 1) && (dim_m <= max_dim) &&
      (dim_n >= 1) && (dim_n <= max_dim) &&
      (dim_p >= 1) && (dim_p <= max_dim))
    else $error("start with dimension outside 1..%0d", max_dim);

endmodule

//--- hdl/wb_host_port.sv
module wb_host_port (
  input  logic                          arm_clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [mm_pkg::adr_width-1:0]  wb_adr,
  input  logic [mm_pkg::data_width-1:0] wb_dat_i,
  output logic [mm_pkg::data_width-1:0] wb_dat_o,
  output logic                          wb_ack,
  input  logic                          done,
  output logic                          start,
  output mm_pkg::dim_t                  dim_m,
  output mm_pkg::dim_t                  dim_n,
  output mm_pkg::dim_t                  dim_p,
  output logic                          feat_we,
  output logic                          weight_we,
  output logic [mm_pkg::off_width-1:0]  host_adr,
  output mm_pkg::feat_word_t            host_wdata,
  input  mm_pkg::feat_word_t            feat_rdata,
  input  mm_pkg::feat_word_t            weight_rdata,
  input  mm_pkg::acc_t                  out_rdata
);

  logic                          req;
  logic                          wr;
  logic [1:0]                    region;
  logic [1:0]                    rd_region;
  logic [mm_pkg::off_width-1:0]  rd_off;
  logic [mm_pkg::data_width-1:0] flag;
  logic [mm_pkg::data_width-1:0] com1;
  logic [mm_pkg::data_width-1:0] com2;
  logic [mm_pkg::data_width-1:0] reg_rdata;

  assign req = wb_cyc && wb_stb && !wb_ack; // new access, ack not yet given
  assign wr = req && wb_we;
  assign region = wb_adr[mm_pkg::adr_width-1 -: 2];
  assign host_adr = wb_adr[mm_pkg::off_width-1:0];
  assign host_wdata = wb_dat_i;

  // writes land in the request cycle, output region writes go nowhere
  assign feat_we = wr && (region == mm_pkg::region_feat);
  assign weight_we = wr && (region == mm_pkg::region_weight);

  assign dim_m = com1[15:0];
  assign dim_p = com1[31:16];
  assign dim_n = com2[15:0];

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      wb_ack <= 1'b0;
      start <= 1'b0;
      flag <= mm_pkg::flag_idle;
      com1 <= '0;
      com2 <= '0;
    end else begin
      wb_ack <= req;
      start <= 1'b0;
      if (wr && (region == mm_pkg::region_ctrl)) begin
        case (host_adr)
          mm_pkg::reg_flag: begin
            if (wb_dat_i == mm_pkg::flag_start) begin // other codes ignored
              flag <= mm_pkg::flag_start;
              start <= 1'b1;
            end
          end
          mm_pkg::reg_com1: com1 <= wb_dat_i;
          mm_pkg::reg_com2: com2 <= wb_dat_i;
          default: ;
        endcase
      end
      if (done) begin
        flag <= mm_pkg::flag_finish;
      end
    end
  end

  // read select follows the buffers' registered read by one cycle
  always_ff @(posedge arm_clk) begin
    if (req) begin
      rd_region <= region;
      rd_off <= host_adr;
    end
  end

  always_comb begin
    case (rd_off)
      mm_pkg::reg_flag: reg_rdata = flag;
      mm_pkg::reg_com1: reg_rdata = com1;
      mm_pkg::reg_com2: reg_rdata = com2;
      default: reg_rdata = '0;
    endcase
  end

  always_comb begin
    case (rd_region)
      mm_pkg::region_ctrl: wb_dat_o = reg_rdata;
      mm_pkg::region_feat: wb_dat_o = feat_rdata;
      mm_pkg::region_weight: wb_dat_o = weight_rdata;
      mm_pkg::region_out: wb_dat_o = out_rdata;
      default: wb_dat_o = '0;
    endcase
  end

  // ack only answers a request seen on the previous clock
  ack_needs_req: assert property (@(posedge arm_clk) disable iff (rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack rose without cyc and stb");

endmodule

//--- hdl/mm_buffer.sv
module mm_buffer #(
  parameter int depth = 16,
  parameter type word_t = logic [31:0],
  localparam int aw = $clog2(depth)
) (
  input  logic          arm_clk,
  input  logic          a_we,
  input  logic [aw-1:0] a_adr,
  input  word_t         a_wdata,
  output word_t         a_rdata,
  input  logic          b_we,
  input  logic [aw-1:0] b_adr,
  input  word_t         b_wdata,
  output word_t         b_rdata
);

  word_t mem [depth];

  // both ports read old data on a same-cycle write
  always_ff @(posedge arm_clk) begin
    if (a_we) begin
      mem[a_adr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_adr] <= b_wdata;
    end
    a_rdata <= mem[a_adr];
    b_rdata <= mem[b_adr];
  end

  // depth need not be a power of two
  wr_in_range: assert property (@(posedge arm_clk)
    (a_we |-> a_adr < depth) and (b_we |-> b_adr < depth))
    else $error("buffer write beyond depth %0d", depth);

endmodule

//--- hdl/mm_pkg.sv
package mm_pkg;

  // host bus and element geometry
  localparam int data_width = 32;
  localparam int elem_width = 8;
  localparam int lanes = 4; // elements per packed word
  localparam int adr_width = 10;
  localparam int off_width = adr_width - 2; // word offset inside a region

  // word address map, region sits in the top two address bits
  localparam logic [1:0] region_ctrl = 2'd0;
  localparam logic [1:0] region_feat = 2'd1;
  localparam logic [1:0] region_weight = 2'd2;
  localparam logic [1:0] region_out = 2'd3;

  // control region registers
  localparam logic [off_width-1:0] reg_flag = off_width'(0);
  localparam logic [off_width-1:0] reg_com1 = off_width'(1);
  localparam logic [off_width-1:0] reg_com2 = off_width'(2);

  localparam logic [data_width-1:0] flag_idle = 32'd0;
  localparam logic [data_width-1:0] flag_start = 32'd1;
  localparam logic [data_width-1:0] flag_finish = 32'd2;

  typedef logic [15:0] dim_t;
  typedef logic [lanes-1:0][elem_width-1:0] feat_word_t; // lane 0 in the low byte
  typedef logic signed [data_width-1:0] acc_t;

  // feature or weight buffer depth, one column of packed words per k
  function automatic int fw_depth(int md);
    return md * ((md + lanes - 1) / lanes);
  endfunction

  // result buffer depth
  function automatic int out_depth(int md);
    return md * md;
  endfunction

endpackage
